// ==== cache_to_dram.f ====
source/cache_to_dram_pkg.sv
source/cache_to_dram_arbiter.sv
source/cache_to_dram_tx.sv
source/cache_to_dram_rx.sv
source/cache_to_dram_ctrl.sv
verif/cache_to_dram_assertions.sv
verif/tb_cache_to_dram.sv

// ==== Makefile ====
# Verilator build and run of the cache-to-DRAM bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_cache_to_dram
FILELIST  ?= cache_to_dram.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := TEST OK

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_cache_to_dram.sv ====
/*
 * Testbench for the cache-to-DRAM bridge. Random DMA traffic from an LFSR
 * runs against a behavioral MIG style controller with a word memory, and
 * every returned read word is checked against a per-port expected queue.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_cache_to_dram;

  localparam int run_cycles_lp = 3000;
  localparam int drain_limit_lp = 2000;

  typedef logic [cache_to_dram_pkg::dma_data_width_lp-1:0] word_t;

  logic clk;
  logic reset;

  cache_to_dram_pkg::dma_pkt_s [cache_to_dram_pkg::num_dma_lp-1:0] dma_pkt;
  logic [cache_to_dram_pkg::num_dma_lp-1:0] dma_pkt_v, dma_pkt_yumi;
  word_t [cache_to_dram_pkg::num_dma_lp-1:0] dma_rdata, dma_wdata;
  logic [cache_to_dram_pkg::num_dma_lp-1:0] dma_rdata_v, dma_rdata_ready;
  logic [cache_to_dram_pkg::num_dma_lp-1:0] dma_wdata_v, dma_wdata_yumi;
  cache_to_dram_pkg::app_cmd_s app_cmd;
  logic app_en, app_rdy;
  word_t app_wdf_data, app_rd_data;
  logic app_wdf_wren, app_wdf_end, app_wdf_rdy;
  logic app_rd_data_valid, app_rd_data_end;

  // controller memory and the expected copy, 16 bursts of 4 words
  word_t mem_model [64];
  word_t mem_ref [64];
  word_t exp_q [cache_to_dram_pkg::num_dma_lp][$];
  word_t wdata_q [cache_to_dram_pkg::num_dma_lp][$];
  word_t wdf_q [$];
  cache_to_dram_pkg::app_cmd_s cmd_q [$];
  logic [cache_to_dram_pkg::num_dma_lp-1:0] yumi_seen;
  logic [31:0] lfsr;
  int gap;
  int beat;

  cache_to_dram_ctrl i_cache_to_dram_ctrl (
    .clk_i               (clk),
    .reset_i             (reset),
    .dma_pkt_i           (dma_pkt),
    .dma_pkt_v_i         (dma_pkt_v),
    .dma_pkt_yumi_o      (dma_pkt_yumi),
    .dma_rdata_o         (dma_rdata),
    .dma_rdata_v_o       (dma_rdata_v),
    .dma_rdata_ready_i   (dma_rdata_ready),
    .dma_wdata_i         (dma_wdata),
    .dma_wdata_v_i       (dma_wdata_v),
    .dma_wdata_yumi_o    (dma_wdata_yumi),
    .app_cmd_o           (app_cmd),
    .app_en_o            (app_en),
    .app_rdy_i           (app_rdy),
    .app_wdf_data_o      (app_wdf_data),
    .app_wdf_wren_o      (app_wdf_wren),
    .app_wdf_end_o       (app_wdf_end),
    .app_wdf_rdy_i       (app_wdf_rdy),
    .app_rd_data_i       (app_rd_data),
    .app_rd_data_valid_i (app_rd_data_valid),
    .app_rd_data_end_i   (app_rd_data_end)
  );

  bind cache_to_dram_ctrl cache_to_dram_assertions i_assertions (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .dma_pkt_v_i    (dma_pkt_v_i),
    .dma_pkt_yumi_i (dma_pkt_yumi_o),
    .app_cmd_i      (app_cmd_o),
    .app_en_i       (app_en_o),
    .app_rdy_i      (app_rdy_i),
    .app_wdf_wren_i (app_wdf_wren_o),
    .app_wdf_end_i  (app_wdf_end_o),
    .app_wdf_rdy_i  (app_wdf_rdy_i),
    .dma_rdata_v_i  (dma_rdata_v_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ************************************************************************
  // helpers
  // ************************************************************************

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic show_mismatch(input string name, input word_t got, input word_t exp);
    stop_run($sformatf("ERR t=%0t %s got %08h expected %08h", $time, name, got, exp));
  endtask

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic int word_index(input logic [cache_to_dram_pkg::addr_width_lp-1:0] addr);
    return int'(addr[7:2]);
  endfunction

  function automatic logic all_idle();
    logic idle;
    idle = (cmd_q.size() == 0) && (wdf_q.size() == 0) && (dma_pkt_v == '0);
    for (int p = 0; p < cache_to_dram_pkg::num_dma_lp; p++) begin
      idle = idle && (exp_q[p].size() == 0) && (wdata_q[p].size() == 0);
    end
    return idle;
  endfunction

  // ************************************************************************
  // behavioral controller, serves commands strictly in order
  // ************************************************************************

  task automatic drive_controller();
    logic [31:0] r;
    int base;
    app_rd_data_valid = 1'b0;
    app_rd_data_end = 1'b0;
    if (cmd_q.size() > 0) begin
      base = word_index(cmd_q[0].addr);
      if (cmd_q[0].cmd == cache_to_dram_pkg::e_app_wr) begin
        if (wdf_q.size() > 0) begin
          mem_model[base + beat] = wdf_q.pop_front();
          beat++;
        end
      end else if (gap > 0) begin
        gap--;
      end else begin
        app_rd_data = mem_model[base + beat];
        app_rd_data_valid = 1'b1;
        app_rd_data_end = (beat == cache_to_dram_pkg::dram_burst_len_lp - 1);
        beat++;
        if (beat == cache_to_dram_pkg::dram_burst_len_lp) begin
          take_bits(2, r);
          gap = int'(r[1:0]);
        end
      end
      if (beat == cache_to_dram_pkg::dram_burst_len_lp) begin
        beat = 0;
        cmd_q.delete(0);
      end
    end
  endtask

  // called just after the rising edge
  task automatic drive_inputs(input logic allow_new);
    logic [31:0] r;
    for (int p = 0; p < cache_to_dram_pkg::num_dma_lp; p++) begin
      if (yumi_seen[p]) begin
        dma_pkt_v[p] = 1'b0;
        yumi_seen[p] = 1'b0;
      end
      // a request is held steady until it is taken
      if (!dma_pkt_v[p] && allow_new) begin
        take_bits(1, r);
        if (r[0]) begin
          take_bits(5, r);
          dma_pkt[p].write_not_read = r[4];
          dma_pkt[p].addr = '0;
          dma_pkt[p].addr[7:4] = r[3:0];
          dma_pkt_v[p] = 1'b1;
        end
      end
      take_bits(1, r);
      if (wdata_q[p].size() > 0) begin
        dma_wdata[p] = wdata_q[p][0];
        dma_wdata_v[p] = r[0];
      end else begin
        dma_wdata[p] = '0;
        dma_wdata_v[p] = 1'b0;
      end
      take_bits(1, r);
      dma_rdata_ready[p] = r[0];
    end
    take_bits(2, r);
    app_rdy = (r[1:0] != 2'b00);
    take_bits(2, r);
    app_wdf_rdy = (r[1:0] != 2'b00);
    drive_controller();
  endtask

  // called late in the cycle, sees the handshakes of the coming edge
  task automatic observe_edge();
    logic [31:0] r;
    int base;
    word_t exp_word;
    for (int p = 0; p < cache_to_dram_pkg::num_dma_lp; p++) begin
      if (dma_pkt_v[p] && dma_pkt_yumi[p]) begin
        yumi_seen[p] = 1'b1;
        base = word_index(dma_pkt[p].addr);
        for (int w = 0; w < cache_to_dram_pkg::dma_burst_len_lp; w++) begin
          if (dma_pkt[p].write_not_read) begin
            take_bits(32, r);
            wdata_q[p].push_back(r);
            mem_ref[base + w] = r;
          end else begin
            exp_q[p].push_back(mem_ref[base + w]);
          end
        end
      end
      if (dma_wdata_yumi[p]) begin
        assert (dma_wdata_v[p])
          else stop_run("dma_wdata_yumi_o was raised while the port offered no write word");
        wdata_q[p].delete(0);
      end
      if (dma_rdata_v[p] && dma_rdata_ready[p]) begin
        assert (exp_q[p].size() > 0)
          else stop_run($sformatf("port %0d received read data it never asked for", p));
        exp_word = exp_q[p].pop_front();
        assert (dma_rdata[p] == exp_word)
          else show_mismatch($sformatf("dma_rdata_o[%0d]", p), dma_rdata[p], exp_word);
      end
    end
    if (app_en && app_rdy) begin
      cmd_q.push_back(app_cmd);
    end
    if (app_wdf_wren && app_wdf_rdy) begin
      wdf_q.push_back(app_wdf_data);
    end
  endtask

  task automatic step_cycle(input logic allow_new);
    drive_inputs(allow_new);
    #2;
    observe_edge();
    @(posedge clk);
    #1;
  endtask

  always @(negedge clk) begin
    if (i_cache_to_dram_ctrl.i_assertions.fail_count != 0) begin
      stop_run("a bound protocol assertion failed");
    end
  end

  // ************************************************************************
  // main sequence
  // ************************************************************************

  initial begin
    int wait_cnt;
    lfsr = 32'h5d79;
    reset = 1'b1;
    dma_pkt = '0;
    dma_pkt_v = '0;
    dma_wdata = '0;
    dma_wdata_v = '0;
    dma_rdata_ready = '0;
    app_rdy = 1'b0;
    app_wdf_rdy = 1'b0;
    app_rd_data = '0;
    app_rd_data_valid = 1'b0;
    app_rd_data_end = 1'b0;
    yumi_seen = '0;
    gap = 0;
    beat = 0;
    for (int i = 0; i < 64; i++) begin
      mem_model[i] = word_t'(i);
      mem_ref[i] = word_t'(i);
    end
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    for (int c = 0; c < run_cycles_lp; c++) begin
      step_cycle(1'b1);
    end

    // no new requests, let everything in flight come back
    wait_cnt = 0;
    while (!all_idle()) begin
      step_cycle(1'b0);
      wait_cnt++;
      if (wait_cnt > drain_limit_lp) begin
        stop_run("timeout while draining outstanding reads, writes and commands");
      end
    end

    if (i_cache_to_dram_ctrl.i_assertions.fail_count == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      stop_run("a bound protocol assertion failed");
    end
  end

endmodule

`default_nettype wire

// ==== verif/cache_to_dram_assertions.sv ====
/*
 * Protocol checks for the bridge top level, attached with bind. Failures are
 * counted in fail_count so the testbench top can end the run.
 */

`timescale 1ns/1ps
`default_nettype none

module cache_to_dram_assertions (
  input logic                                         clk_i,
  input logic                                         reset_i,
  input logic [cache_to_dram_pkg::num_dma_lp-1:0]     dma_pkt_v_i,
  input logic [cache_to_dram_pkg::num_dma_lp-1:0]     dma_pkt_yumi_i,
  input cache_to_dram_pkg::app_cmd_s                  app_cmd_i,
  input logic                                         app_en_i,
  input logic                                         app_rdy_i,
  input logic                                         app_wdf_wren_i,
  input logic                                         app_wdf_end_i,
  input logic                                         app_wdf_rdy_i,
  input logic [cache_to_dram_pkg::num_dma_lp-1:0]     dma_rdata_v_i
);

  int unsigned fail_count = 0;

  logic [cache_to_dram_pkg::num_dma_lp-1:0] last_grant_r;
  logic                                     wdf_odd_r;

  // last granted port starts at the top one so port 0 wins first
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_grant_r <= {1'b1, {(cache_to_dram_pkg::num_dma_lp-1){1'b0}}};
      wdf_odd_r <= 1'b0;
    end else begin
      if (|dma_pkt_yumi_i) begin
        last_grant_r <= dma_pkt_yumi_i;
      end
      if (app_wdf_wren_i && app_wdf_rdy_i) begin
        wdf_odd_r <= !wdf_odd_r;
      end
    end
  end

  // ************************************************************************
  // properties
  // ************************************************************************

  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    (dma_pkt_yumi_i & ~dma_pkt_v_i) == '0)
  else begin
    fail_count = fail_count + 1;
    $error("dma_pkt_yumi_o raised for a port without dma_pkt_v_i");
  end

  // with every port asking, the last winner must not win again
  round_robin_fair: assert property (@(posedge clk_i) disable iff (reset_i)
    ((|dma_pkt_yumi_i) && (&dma_pkt_v_i)) |-> ((dma_pkt_yumi_i & last_grant_r) == '0))
  else begin
    fail_count = fail_count + 1;
    $error("a port was granted twice in a row while the other port waited");
  end

  cmd_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (app_en_i && !app_rdy_i) |=> (app_en_i && $stable(app_cmd_i)))
  else begin
    fail_count = fail_count + 1;
    $error("app_en_o or app_cmd_o changed before the command was accepted");
  end

  wdf_end_every_second: assert property (@(posedge clk_i) disable iff (reset_i)
    app_wdf_end_i == (app_wdf_wren_i && wdf_odd_r))
  else begin
    fail_count = fail_count + 1;
    $error("app_wdf_end_o does not mark every second write word");
  end

  reset_quiet: assert property (@(posedge clk_i)
    reset_i |-> (!app_en_i && !app_wdf_wren_i && dma_pkt_yumi_i == '0 && dma_rdata_v_i == '0))
  else begin
    fail_count = fail_count + 1;
    $error("a control output is high while reset_i is high");
  end

endmodule

`default_nettype wire

// ==== source/cache_to_dram_ctrl.sv ====
/*
 * Top level of the bridge. Two cache DMA ports share one MIG style
 * application interface through the arbiter, transmit and receive blocks.
 */

`timescale 1ns/1ps
`default_nettype none

module cache_to_dram_ctrl (
  input  logic                                                   clk_i,
  input  logic                                                   reset_i,

  // DMA ports
  input  cache_to_dram_pkg::dma_pkt_s [cache_to_dram_pkg::num_dma_lp-1:0] dma_pkt_i,
  input  logic [cache_to_dram_pkg::num_dma_lp-1:0]               dma_pkt_v_i,
  output logic [cache_to_dram_pkg::num_dma_lp-1:0]               dma_pkt_yumi_o,

  output logic [cache_to_dram_pkg::num_dma_lp-1:0]
               [cache_to_dram_pkg::dma_data_width_lp-1:0]        dma_rdata_o,
  output logic [cache_to_dram_pkg::num_dma_lp-1:0]               dma_rdata_v_o,
  input  logic [cache_to_dram_pkg::num_dma_lp-1:0]               dma_rdata_ready_i,

  input  logic [cache_to_dram_pkg::num_dma_lp-1:0]
               [cache_to_dram_pkg::dma_data_width_lp-1:0]        dma_wdata_i,
  input  logic [cache_to_dram_pkg::num_dma_lp-1:0]               dma_wdata_v_i,
  output logic [cache_to_dram_pkg::num_dma_lp-1:0]               dma_wdata_yumi_o,

  // memory controller application interface
  output cache_to_dram_pkg::app_cmd_s                            app_cmd_o,
  output logic                                                   app_en_o,
  input  logic                                                   app_rdy_i,

  output logic [cache_to_dram_pkg::dma_data_width_lp-1:0]        app_wdf_data_o,
  output logic                                                   app_wdf_wren_o,
  output logic                                                   app_wdf_end_o,
  input  logic                                                   app_wdf_rdy_i,

  input  logic [cache_to_dram_pkg::dma_data_width_lp-1:0]        app_rd_data_i,
  input  logic                                                   app_rd_data_valid_i,
  input  logic                                                   app_rd_data_end_i
);

  // tag channels from the arbiter
  cache_to_dram_pkg::dma_id_t wr_tag_lo;
  logic wr_tag_v_lo;
  logic wr_tag_ready_li;
  cache_to_dram_pkg::dma_id_t rd_tag_lo;
  logic rd_tag_v_lo;
  logic rd_tag_ready_li;

  cache_to_dram_arbiter i_arbiter (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .dma_pkt_i      (dma_pkt_i),
    .dma_pkt_v_i    (dma_pkt_v_i),
    .dma_pkt_yumi_o (dma_pkt_yumi_o),
    .app_cmd_o      (app_cmd_o),
    .app_en_o       (app_en_o),
    .app_rdy_i      (app_rdy_i),
    .wr_tag_o       (wr_tag_lo),
    .wr_tag_v_o     (wr_tag_v_lo),
    .wr_tag_ready_i (wr_tag_ready_li),
    .rd_tag_o       (rd_tag_lo),
    .rd_tag_v_o     (rd_tag_v_lo),
    .rd_tag_ready_i (rd_tag_ready_li)
  );

  cache_to_dram_tx i_tx (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .wr_tag_i         (wr_tag_lo),
    .wr_tag_v_i       (wr_tag_v_lo),
    .wr_tag_ready_o   (wr_tag_ready_li),
    .dma_wdata_i      (dma_wdata_i),
    .dma_wdata_v_i    (dma_wdata_v_i),
    .dma_wdata_yumi_o (dma_wdata_yumi_o),
    .app_wdf_data_o   (app_wdf_data_o),
    .app_wdf_wren_o   (app_wdf_wren_o),
    .app_wdf_end_o    (app_wdf_end_o),
    .app_wdf_rdy_i    (app_wdf_rdy_i)
  );

  cache_to_dram_rx i_rx (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .rd_tag_i            (rd_tag_lo),
    .rd_tag_v_i          (rd_tag_v_lo),
    .rd_tag_ready_o      (rd_tag_ready_li),
    .app_rd_data_i       (app_rd_data_i),
    .app_rd_data_valid_i (app_rd_data_valid_i),
    .app_rd_data_end_i   (app_rd_data_end_i),
    .dma_rdata_o         (dma_rdata_o),
    .dma_rdata_v_o       (dma_rdata_v_o),
    .dma_rdata_ready_i   (dma_rdata_ready_i)
  );

endmodule

`default_nettype wire

// ==== source/cache_to_dram_rx.sv ====
/*
 * Read data path. Controller read data is buffered with no back-pressure and
 * handed out in DMA bursts to the port named by the oldest read tag.
 */

`timescale 1ns/1ps
`default_nettype none

module cache_to_dram_rx (
  input  logic                                            clk_i,
  input  logic                                            reset_i,

  input  cache_to_dram_pkg::dma_id_t                      rd_tag_i,
  input  logic                                            rd_tag_v_i,
  output logic                                            rd_tag_ready_o,

  input  logic [cache_to_dram_pkg::dma_data_width_lp-1:0] app_rd_data_i,
  input  logic                                            app_rd_data_valid_i,
  input  logic                                            app_rd_data_end_i,

  output logic [cache_to_dram_pkg::num_dma_lp-1:0]
               [cache_to_dram_pkg::dma_data_width_lp-1:0] dma_rdata_o,
  output logic [cache_to_dram_pkg::num_dma_lp-1:0]        dma_rdata_v_o,
  input  logic [cache_to_dram_pkg::num_dma_lp-1:0]        dma_rdata_ready_i
);

  localparam int tag_lg = cache_to_dram_pkg::lg_tag_fifo_els_lp;
  localparam int data_lg = cache_to_dram_pkg::lg_data_fifo_els_lp;

  // ************************************************************************
  // tag FIFO and read-data FIFO, pointers carry one wrap bit
  // ************************************************************************

  cache_to_dram_pkg::dma_id_t tag_mem [cache_to_dram_pkg::tag_fifo_els_lp];
  logic [tag_lg:0] tag_wptr_r, tag_rptr_r;
  logic tag_full, tag_empty, tag_push, tag_pop;

  logic [cache_to_dram_pkg::dma_data_width_lp-1:0] data_mem [cache_to_dram_pkg::data_fifo_els_lp];
  logic [data_lg:0] data_wptr_r, data_rptr_r;
  logic data_empty, data_pop;

  cache_to_dram_pkg::beat_cnt_t beat_cnt_r;
  cache_to_dram_pkg::dma_id_t   head_tag;
  logic [cache_to_dram_pkg::dma_data_width_lp-1:0] head_data;
  logic head_v;

  assign tag_empty = (tag_wptr_r == tag_rptr_r);
  assign tag_full = (tag_wptr_r[tag_lg] != tag_rptr_r[tag_lg]) &&
                    (tag_wptr_r[tag_lg-1:0] == tag_rptr_r[tag_lg-1:0]);
  assign rd_tag_ready_o = !tag_full;
  assign tag_push = rd_tag_v_i && !tag_full;

  assign data_empty = (data_wptr_r == data_rptr_r);

  assign head_tag = tag_mem[tag_rptr_r[tag_lg-1:0]];
  assign head_data = data_mem[data_rptr_r[data_lg-1:0]];
  assign head_v = !tag_empty && !data_empty;

  // a word leaves when the head tag's port takes it
  assign data_pop = head_v && dma_rdata_ready_i[head_tag];
  assign tag_pop = data_pop && (beat_cnt_r == cache_to_dram_pkg::last_beat_lp);

  always_comb begin
    for (int i = 0; i < cache_to_dram_pkg::num_dma_lp; i++) begin
      dma_rdata_o[i] = head_data;
      dma_rdata_v_o[i] = head_v && (head_tag == cache_to_dram_pkg::dma_id_t'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (tag_push) begin
      tag_mem[tag_wptr_r[tag_lg-1:0]] <= rd_tag_i;
    end
    if (app_rd_data_valid_i) begin
      data_mem[data_wptr_r[data_lg-1:0]] <= app_rd_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tag_wptr_r <= '0;
      tag_rptr_r <= '0;
      data_wptr_r <= '0;
      data_rptr_r <= '0;
      beat_cnt_r <= '0;
    end else begin
      if (tag_push) begin
        tag_wptr_r <= tag_wptr_r + 1'b1;
      end
      if (tag_pop) begin
        tag_rptr_r <= tag_rptr_r + 1'b1;
      end
      if (app_rd_data_valid_i) begin
        data_wptr_r <= data_wptr_r + 1'b1;
      end
      // beat count wraps back to zero with the tag pop
      if (data_pop) begin
        data_rptr_r <= data_rptr_r + 1'b1;
        beat_cnt_r <= beat_cnt_r + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/cache_to_dram_tx.sv ====
/*
 * Write data path. After a write tag arrives it streams one DMA burst from
 * that port into the controller's write-data FIFO and marks burst ends.
 */

`timescale 1ns/1ps
`default_nettype none

module cache_to_dram_tx (
  input  logic                                          clk_i,
  input  logic                                          reset_i,

  input  cache_to_dram_pkg::dma_id_t                    wr_tag_i,
  input  logic                                          wr_tag_v_i,
  output logic                                          wr_tag_ready_o,

  input  logic [cache_to_dram_pkg::num_dma_lp-1:0]
               [cache_to_dram_pkg::dma_data_width_lp-1:0] dma_wdata_i,
  input  logic [cache_to_dram_pkg::num_dma_lp-1:0]      dma_wdata_v_i,
  output logic [cache_to_dram_pkg::num_dma_lp-1:0]      dma_wdata_yumi_o,

  output logic [cache_to_dram_pkg::dma_data_width_lp-1:0] app_wdf_data_o,
  output logic                                          app_wdf_wren_o,
  output logic                                          app_wdf_end_o,
  input  logic                                          app_wdf_rdy_i
);

  logic                          busy_r;
  cache_to_dram_pkg::dma_id_t    port_r;
  cache_to_dram_pkg::beat_cnt_t  beat_cnt_r;
  logic                          word_move;

  // only one burst is handled at a time
  assign wr_tag_ready_o = !busy_r;

  assign app_wdf_data_o = dma_wdata_i[port_r];
  assign app_wdf_wren_o = busy_r && dma_wdata_v_i[port_r];
  assign word_move = app_wdf_wren_o && app_wdf_rdy_i;

  // low bits of the beat count give the position inside a controller burst
  assign app_wdf_end_o = app_wdf_wren_o &&
    (beat_cnt_r[cache_to_dram_pkg::lg_dram_burst_len_lp-1:0] == '1);

  always_comb begin
    dma_wdata_yumi_o = '0;
    dma_wdata_yumi_o[port_r] = word_move;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
      port_r <= '0;
      beat_cnt_r <= '0;
    end else if (!busy_r) begin
      if (wr_tag_v_i) begin
        busy_r <= 1'b1;
        port_r <= wr_tag_i;
        beat_cnt_r <= '0;
      end
    end else if (word_move) begin
      beat_cnt_r <= beat_cnt_r + 1'b1;
      // idle again the cycle after the last word of the burst
      if (beat_cnt_r == cache_to_dram_pkg::last_beat_lp) begin
        busy_r <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/cache_to_dram_arbiter.sv ====
/*
 * Round-robin arbiter over the DMA request ports. It takes one packet at a
 * time, issues it as controller commands and hands the port tag to the
 * transmit block (writes) or the receive block (reads).
 */

`timescale 1ns/1ps
`default_nettype none

module cache_to_dram_arbiter (
  input  logic                                                   clk_i,
  input  logic                                                   reset_i,

  input  cache_to_dram_pkg::dma_pkt_s [cache_to_dram_pkg::num_dma_lp-1:0] dma_pkt_i,
  input  logic [cache_to_dram_pkg::num_dma_lp-1:0]               dma_pkt_v_i,
  output logic [cache_to_dram_pkg::num_dma_lp-1:0]               dma_pkt_yumi_o,

  output cache_to_dram_pkg::app_cmd_s                            app_cmd_o,
  output logic                                                   app_en_o,
  input  logic                                                   app_rdy_i,

  output cache_to_dram_pkg::dma_id_t                             wr_tag_o,
  output logic                                                   wr_tag_v_o,
  input  logic                                                   wr_tag_ready_i,

  output cache_to_dram_pkg::dma_id_t                             rd_tag_o,
  output logic                                                   rd_tag_v_o,
  input  logic                                                   rd_tag_ready_i
);

  // e_init keeps the request side quiet for the cycle reset is held
  typedef enum logic [1:0] {e_init, e_idle, e_cmd} state_e;

  state_e                          state_r;
  cache_to_dram_pkg::req_cnt_t     req_cnt_r;
  cache_to_dram_pkg::dma_id_t      last_r;
  cache_to_dram_pkg::dma_id_t      tag_r;
  logic                            write_r;
  logic [cache_to_dram_pkg::addr_width_lp-1:0] addr_r;

  cache_to_dram_pkg::dma_id_t      cand;
  cache_to_dram_pkg::dma_id_t      grant_idx;
  cache_to_dram_pkg::dma_pkt_s     grant_pkt;
  logic                            grant_found;
  logic                            chan_ready;
  logic                            pkt_take;
  logic                            cmd_accept;
  logic                            first_accept;

  // ************************************************************************
  // port selection, starting one past the last granted port
  // ************************************************************************

  always_comb begin
    grant_found = 1'b0;
    grant_idx = '0;
    cand = '0;
    for (int i = 0; i < cache_to_dram_pkg::num_dma_lp; i++) begin
      cand = last_r + cache_to_dram_pkg::dma_id_t'(i + 1);
      if (!grant_found && dma_pkt_v_i[cand]) begin
        grant_found = 1'b1;
        grant_idx = cand;
      end
    end
  end

  assign grant_pkt = dma_pkt_i[grant_idx];

  // a blocked port is not skipped, so the other port cannot win twice in a row
  assign chan_ready = grant_pkt.write_not_read ? wr_tag_ready_i : rd_tag_ready_i;
  assign pkt_take = (state_r == e_idle) && grant_found && chan_ready;

  always_comb begin
    dma_pkt_yumi_o = '0;
    dma_pkt_yumi_o[grant_idx] = pkt_take;
  end

  // ************************************************************************
  // command issue
  // ************************************************************************

  assign app_en_o = (state_r == e_cmd);
  assign app_cmd_o.cmd = write_r ? cache_to_dram_pkg::e_app_wr : cache_to_dram_pkg::e_app_rd;
  assign app_cmd_o.addr = addr_r;

  assign cmd_accept = app_en_o && app_rdy_i;
  assign first_accept = cmd_accept && (req_cnt_r == '0);

  // the tag goes out with the packet's first command
  assign wr_tag_o = tag_r;
  assign wr_tag_v_o = first_accept && write_r;
  assign rd_tag_o = tag_r;
  assign rd_tag_v_o = first_accept && !write_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_init;
      req_cnt_r <= '0;
      last_r <= '1;
    end else begin
      case (state_r)
        e_init: state_r <= e_idle;
        e_idle: begin
          if (pkt_take) begin
            state_r <= e_cmd;
            last_r <= grant_idx;
            req_cnt_r <= '0;
          end
        end
        e_cmd: begin
          if (cmd_accept) begin
            if (req_cnt_r == cache_to_dram_pkg::last_req_lp) begin
              state_r <= e_idle;
              req_cnt_r <= '0;
            end else begin
              req_cnt_r <= req_cnt_r + 1'b1;
            end
          end
        end
        default: state_r <= e_idle;
      endcase
    end
  end

  // held packet, the address steps one controller burst per accepted command
  always_ff @(posedge clk_i) begin
    if (pkt_take) begin
      write_r <= grant_pkt.write_not_read;
      addr_r <= grant_pkt.addr;
      tag_r <= grant_idx;
    end else if (cmd_accept) begin
      addr_r <= addr_r + cache_to_dram_pkg::dram_burst_bytes_lp;
    end
  end

endmodule

`default_nettype wire

// ==== source/cache_to_dram_pkg.sv ====
/*
 * Shared sizes, types and controller opcodes for the cache-to-DRAM bridge.
 * Modules reach these through scoped names such as cache_to_dram_pkg::dma_pkt_s.
 */

`default_nettype none

package cache_to_dram_pkg;

  // port and data sizes
  localparam int num_dma_lp = 2;
  localparam int lg_num_dma_lp = $clog2(num_dma_lp);
  localparam int dma_data_width_lp = 32;
  localparam int addr_width_lp = 28;

  // one DMA burst is split into num_req_lp controller commands
  localparam int dma_burst_len_lp = 4;
  localparam int lg_dma_burst_len_lp = $clog2(dma_burst_len_lp);
  localparam int dram_burst_len_lp = 2;
  localparam int lg_dram_burst_len_lp = $clog2(dram_burst_len_lp);
  localparam int num_req_lp = dma_burst_len_lp / dram_burst_len_lp;
  localparam int lg_num_req_lp = $clog2(num_req_lp);

  // the read buffer holds every word of every read tag that can be in flight
  localparam int tag_fifo_els_lp = 4;
  localparam int lg_tag_fifo_els_lp = $clog2(tag_fifo_els_lp);
  localparam int data_fifo_els_lp = tag_fifo_els_lp * dma_burst_len_lp;
  localparam int lg_data_fifo_els_lp = $clog2(data_fifo_els_lp);

  typedef logic [lg_num_dma_lp-1:0] dma_id_t;
  typedef logic [lg_dma_burst_len_lp-1:0] beat_cnt_t;
  typedef logic [lg_num_req_lp-1:0] req_cnt_t;

  localparam beat_cnt_t last_beat_lp = beat_cnt_t'(dma_burst_len_lp - 1);
  localparam req_cnt_t last_req_lp = req_cnt_t'(num_req_lp - 1);

  // byte step between the commands of one DMA burst
  localparam logic [addr_width_lp-1:0] dram_burst_bytes_lp =
    addr_width_lp'(dram_burst_len_lp * dma_data_width_lp / 8);

  // MIG style command encoding
  typedef enum logic [2:0] {
    e_app_wr = 3'b000,
    e_app_rd = 3'b001
  } app_cmd_e;

  typedef struct packed {
    logic                     write_not_read;
    logic [addr_width_lp-1:0] addr;
  } dma_pkt_s;

  typedef struct packed {
    app_cmd_e                 cmd;
    logic [addr_width_lp-1:0] addr;
  } app_cmd_s;

endpackage

`default_nettype wire
